/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* bench/lsu_sva.sv */
`timescale 1ns/1ps

module lsu_sva_props
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
(
   input logic                clk,
   input logic                nrst,
   input logic                o_disp_ready,
   input logic                o_mem_valid,
   input logic [OP_W-1:0]     o_mem_op,
   input logic [TAG_W-1:0]    o_mem_rob,
   input logic [DATA_W-1:0]   o_mem_addr,
   input logic [DATA_W-1:0]   o_mem_data,
   input logic                i_mem_ready,
   input logic [ST_CNT_W-1:0] st_count,
   input logic [SQ_CNT_W-1:0] sq_count
);

   // request holds while memory stalls.
   a_mem_stable: assert property (@(posedge clk) disable iff (nrst)
      o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_op) &&
      $stable(o_mem_rob) && $stable(o_mem_addr) && $stable(o_mem_data))
      else $error("memory request changed under back-pressure");

   a_reset_idle: assert property (@(posedge clk) nrst |=> !o_mem_valid)
      else $error("memory request during reset");

   // neither buffer grows while dispatch is held off.
   a_no_disp_stalled: assert property (@(posedge clk) disable iff (nrst)
      !o_disp_ready |=> (st_count <= $past(st_count)) && (sq_count <= $past(sq_count)))
      else $error("instruction taken while dispatch not ready");

endmodule

bind lsu_top lsu_sva_props u_sva (.*, .st_count(u_station.count), .sq_count(u_queue.count));

/* bench/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
();

   localparam int N_INSTR   = 200;
   localparam int WD_CYCLES = N_INSTR * 50;

   logic clk, nrst, i_disp_valid, i_base_rdy, i_sdata_rdy, o_disp_ready;
   mem_op_e i_disp_op, o_mem_op;
   logic [TAG_W-1:0] i_disp_rob, i_base_tag, i_sdata_tag, i_cdb_tag, i_commit_rob, o_mem_rob;
   logic [DATA_W-1:0] i_base_val, i_offset, i_sdata_val, i_cdb_data, o_mem_addr, o_mem_data;
   logic i_cdb_valid, i_commit_valid, o_mem_valid, i_mem_ready;

   integer seed = 32'h2ac1f0cf;
   mem_op_e op_q [N_INSTR];
   logic st_flag [N_INSTR];
   logic [DATA_W-1:0] base_q [N_INSTR], off_q [N_INSTR], sd_q [N_INSTR];
   logic accepted [N_INSTR], committed [N_INSTR], completed [N_INSTR];
   logic tag_busy [16], tag_armed [16];
   logic [DATA_W-1:0] tag_data [16];
   int st_list [N_INSTR];
   int ld_exp [$], st_exp [$];
   int n_st, commit_ptr, commit_cur, disp_idx, oldest, done_cnt, pres_btag, pres_stag;
   logic presenting, held;
   logic [DATA_W-1:0] held_addr, held_data;

   lsu_top i_dut (.*);

   always #2 clk = ~clk;

   function automatic int rand_pct();
      return {$random(seed)} % 100;
   endfunction

   task automatic compare_field(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
      assert (exp === act) else begin
         $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_failure(input string what);
      $display("failure at t=%0t: %s", $time, what);
      $display("TEST FAIL");
      $fatal(1, "check failed");
   endtask

   // returns -1 when every tag is taken.
   function automatic int alloc_tag(input logic [DATA_W-1:0] val);
      int start, t;
      start = {$random(seed)} % 16;
      for (int k = 0; k < 16; k++) begin
         t = (start + k) % 16;
         if (!tag_busy[t]) begin
            tag_busy[t] = 1'b1;
            tag_data[t] = val;
            return t;
         end
      end
      return -1;
   endfunction

   task automatic check_request();
      int idx;
      if (o_mem_op inside {OP_SW, OP_SB, OP_SH}) begin
         assert (st_exp.size() > 0) else report_failure("store request with none pending");
         idx = st_exp.pop_front();
         assert (committed[idx]) else report_failure("store issued before its commit");
         compare_field("o_mem_data", sd_q[idx], o_mem_data);
      end else begin
         assert (ld_exp.size() > 0) else report_failure("load request with none pending");
         idx = ld_exp.pop_front();
         compare_field("o_mem_data", '0, o_mem_data);
         for (int j = 0; j < idx; j++) begin
            assert (!(st_flag[j] && !completed[j] && (base_q[j] + off_q[j] == o_mem_addr)))
               else report_failure("load passed an older store to the same address");
         end
      end
      compare_field("o_mem_op", DATA_W'(op_q[idx]), DATA_W'(o_mem_op));
      compare_field("o_mem_rob", idx % 16, DATA_W'(o_mem_rob));
      compare_field("o_mem_addr", base_q[idx] + off_q[idx], o_mem_addr);
      completed[idx] = 1'b1;
      done_cnt++;
      while (oldest < N_INSTR && completed[oldest]) oldest++;
   endtask

   task automatic drive_dispatch();
      int t;
      if (presenting) return;
      i_disp_valid <= 1'b0;
      if (disp_idx >= N_INSTR || disp_idx >= oldest + 15 || rand_pct() >= 60) return;
      presenting = 1'b1;
      pres_btag = -1;
      pres_stag = -1;
      if (rand_pct() < 50) pres_btag = alloc_tag(base_q[disp_idx]);
      if (st_flag[disp_idx] && rand_pct() < 50) pres_stag = alloc_tag(sd_q[disp_idx]);
      t = {$random(seed)} % 16;
      i_disp_valid <= 1'b1;
      i_disp_op    <= op_q[disp_idx];
      i_disp_rob   <= TAG_W'(disp_idx % 16);
      i_offset     <= off_q[disp_idx];
      i_base_rdy   <= (pres_btag < 0);
      i_base_tag   <= TAG_W'((pres_btag < 0) ? t : pres_btag);
      i_base_val   <= (pres_btag < 0) ? base_q[disp_idx] : $random(seed);
      i_sdata_rdy  <= (pres_stag < 0);
      i_sdata_tag  <= TAG_W'((pres_stag < 0) ? t : pres_stag);
      i_sdata_val  <= (pres_stag < 0) ? sd_q[disp_idx] : $random(seed);
   endtask

   task automatic drive_cdb();
      int start, t;
      i_cdb_valid <= 1'b0;
      if (rand_pct() >= 40) return;
      start = {$random(seed)} % 16;
      for (int k = 0; k < 16; k++) begin
         t = (start + k) % 16;
         if (tag_armed[t]) begin
            tag_armed[t] = 1'b0;
            i_cdb_valid <= 1'b1;
            i_cdb_tag   <= TAG_W'(t);
            i_cdb_data  <= tag_data[t];
            return;
         end
      end
   endtask

   initial begin
      int sel;
      clk = 1'b0;
      nrst = 1'b1;
      i_disp_valid = 1'b0;
      i_disp_op = OP_LW;
      i_disp_rob = '0;
      i_base_val = '0;
      i_base_tag = '0;
      i_base_rdy = 1'b0;
      i_offset = '0;
      i_sdata_val = '0;
      i_sdata_tag = '0;
      i_sdata_rdy = 1'b0;
      i_cdb_valid = 1'b0;
      i_cdb_tag = '0;
      i_cdb_data = '0;
      i_commit_valid = 1'b0;
      i_commit_rob = '0;
      i_mem_ready = 1'b0;
      n_st = 0;
      for (int i = 0; i < N_INSTR; i++) begin
         sel = {$random(seed)} % 6;
         case (sel)
            0: op_q[i] = OP_LW;
            1: op_q[i] = OP_LB;
            2: op_q[i] = OP_LH;
            3: op_q[i] = OP_SW;
            4: op_q[i] = OP_SB;
            default: op_q[i] = OP_SH;
         endcase
         st_flag[i] = (sel >= 3);
         // narrow address range so loads hit older stores.
         base_q[i] = $random(seed) & 32'h3c;
         off_q[i]  = $random(seed) & 32'hc;
         sd_q[i]   = $random(seed);
         accepted[i] = 1'b0;
         committed[i] = 1'b0;
         completed[i] = 1'b0;
         if (st_flag[i]) begin
            st_list[n_st] = i;
            n_st++;
         end
      end
      for (int t = 0; t < 16; t++) begin
         tag_busy[t] = 1'b0;
         tag_armed[t] = 1'b0;
      end
      commit_ptr = 0;
      disp_idx = 0;
      oldest = 0;
      done_cnt = 0;
      presenting = 1'b0;
      held = 1'b0;
      commit_cur = 0;
      repeat (5) @(posedge clk);
      nrst <= 1'b0;
      @(posedge clk);
      compare_field("o_mem_valid", '0, DATA_W'(o_mem_valid));
      compare_field("o_disp_ready", 1, DATA_W'(o_disp_ready));
      while (done_cnt < N_INSTR) begin
         @(posedge clk);
         if (i_commit_valid) committed[commit_cur] = 1'b1;
         // a broadcast tag is free once the DUT has sampled it.
         if (i_cdb_valid) tag_busy[i_cdb_tag] = 1'b0;
         if (i_disp_valid && o_disp_ready) begin
            accepted[disp_idx] = 1'b1;
            if (pres_btag >= 0) tag_armed[pres_btag] = 1'b1;
            if (pres_stag >= 0) tag_armed[pres_stag] = 1'b1;
            if (st_flag[disp_idx]) st_exp.push_back(disp_idx);
            else ld_exp.push_back(disp_idx);
            disp_idx++;
            presenting = 1'b0;
         end
         if (held) begin
            compare_field("o_mem_valid", 1, DATA_W'(o_mem_valid));
            compare_field("o_mem_addr", held_addr, o_mem_addr);
            compare_field("o_mem_data", held_data, o_mem_data);
         end
         held = o_mem_valid && !i_mem_ready;
         held_addr = o_mem_addr;
         held_data = o_mem_data;
         if (o_mem_valid && i_mem_ready) check_request();
         i_mem_ready <= (rand_pct() < 70);
         drive_cdb();
         i_commit_valid <= 1'b0;
         if (commit_ptr < n_st && accepted[st_list[commit_ptr]] && rand_pct() < 30) begin
            commit_cur = st_list[commit_ptr];
            i_commit_valid <= 1'b1;
            i_commit_rob   <= TAG_W'(commit_cur % 16);
            commit_ptr++;
         end
         drive_dispatch();
      end
      $display("TEST PASS");
      $finish;
   end

   initial begin
      #(WD_CYCLES * 4);
      $display("run hung: not all requests reached the memory port in time");
      $display("TEST FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

/* hdl/addr_station.sv */
`timescale 1ns/1ps

module addr_station
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
(
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_disp_valid,
   input  mem_op_e           i_disp_op,
   input  logic [TAG_W-1:0]  i_disp_rob,
   input  logic [DATA_W-1:0] i_base_val,
   input  logic [TAG_W-1:0]  i_base_tag,
   input  logic              i_base_rdy,
   input  logic [DATA_W-1:0] i_offset,
   input  logic              i_cdb_valid,
   input  logic [TAG_W-1:0]  i_cdb_tag,
   input  logic [DATA_W-1:0] i_cdb_data,
   output logic              o_ready,
   lsu_agu_if.station        agu
);

   logic              ent_valid [N_STATIONS];
   logic              ent_rdy   [N_STATIONS];
   mem_op_e           ent_op    [N_STATIONS];
   logic [TAG_W-1:0]  ent_rob   [N_STATIONS];
   logic [TAG_W-1:0]  ent_tag   [N_STATIONS];
   logic [DATA_W-1:0] ent_base  [N_STATIONS];
   logic [DATA_W-1:0] ent_off   [N_STATIONS];

   logic [ST_PTR_W-1:0]   head;
   logic [ST_PTR_W-1:0]   tail;
   logic [ST_CNT_W-1:0]   count;
   logic                  push;
   logic                  pop;
   logic                  new_hit;
   logic [N_STATIONS-1:0] wr_sel;
   logic [N_STATIONS-1:0] cdb_hit;

   assign o_ready = (count != ST_CNT_W'(N_STATIONS));

   // dispatch valid arrives already qualified by the top ready.
   assign push = i_disp_valid;
   assign pop  = agu.valid && agu.ready;

   // a broadcast can satisfy the operand being written.
   assign new_hit = i_cdb_valid && (i_cdb_tag == i_base_tag);

   always_comb begin
      for (int i = 0; i < N_STATIONS; i++) begin
         wr_sel[i]  = push && (tail == ST_PTR_W'(i));
         cdb_hit[i] = ent_valid[i] && !ent_rdy[i] && i_cdb_valid &&
                      (ent_tag[i] == i_cdb_tag);
      end
   end

   // only the head may issue, which keeps dispatch order.
   assign agu.valid = ent_valid[head] && ent_rdy[head];
   assign agu.op    = ent_op[head];
   assign agu.rob   = ent_rob[head];
   assign agu.addr  = ent_base[head] + ent_off[head];

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         for (int i = 0; i < N_STATIONS; i++) begin
            ent_valid[i] <= 1'b0;
            ent_rdy[i]   <= 1'b0;
         end
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (pop) begin
            head <= head + 1'b1;
         end
         case ({push, pop})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count;
            end
         endcase
         for (int i = 0; i < N_STATIONS; i++) begin
            if (wr_sel[i]) begin
               ent_valid[i] <= 1'b1;
               ent_rdy[i]   <= i_base_rdy || new_hit;
            end else if (cdb_hit[i]) begin
               ent_rdy[i] <= 1'b1;
            end
            if (pop && (head == ST_PTR_W'(i))) begin
               ent_valid[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N_STATIONS; i++) begin
         if (wr_sel[i]) begin
            ent_op[i]   <= i_disp_op;
            ent_rob[i]  <= i_disp_rob;
            ent_tag[i]  <= i_base_tag;
            ent_off[i]  <= i_offset;
            ent_base[i] <= i_base_rdy ? i_base_val : i_cdb_data;
         end else if (cdb_hit[i]) begin
            ent_base[i] <= i_cdb_data;
         end
      end
   end

endmodule

/* hdl/lsu_agu_if.sv */
`timescale 1ns/1ps

interface lsu_agu_if
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
();

   logic              valid;
   mem_op_e           op;
   logic [TAG_W-1:0]  rob;
   logic [DATA_W-1:0] addr;
   logic              ready;

   // station produces the address.
   modport station (output valid, op, rob, addr, input ready);

   // queue snoops store addresses and checks loads.
   modport queue (input valid, op, rob, addr, ready);

   // issue stage accepts or holds the result.
   modport issue (input valid, op, rob, addr, output ready);

endinterface

/* hdl/lsu_cfg_pkg.sv */
package lsu_cfg_pkg;

   // data path and address width.
   localparam int DATA_W = 32;

   // rename tags and rob tags share one width.
   localparam int TAG_W = 4;

   // address station entries.
   localparam int N_STATIONS = 4;

   // store queue entries.
   localparam int SQ_DEPTH = 4;

   // pointer widths, depths are powers of two.
   localparam int ST_PTR_W = $clog2(N_STATIONS);
   localparam int SQ_PTR_W = $clog2(SQ_DEPTH);

   // occupancy counters must also hold the full value.
   localparam int ST_CNT_W = $clog2(N_STATIONS + 1);
   localparam int SQ_CNT_W = $clog2(SQ_DEPTH + 1);

endpackage

/* hdl/lsu_isa_pkg.sv */
package lsu_isa_pkg;

   localparam int OP_W = 3;

   // bit 2 set marks a store.
   typedef enum logic [OP_W-1:0] {
      OP_LW = 3'd0,
      OP_LB = 3'd1,
      OP_LH = 3'd2,
      OP_SW = 3'd4,
      OP_SB = 3'd5,
      OP_SH = 3'd6
   } mem_op_e;

   function automatic logic is_store(input mem_op_e op);
      logic st;
      case (op)
         OP_SW,
         OP_SB,
         OP_SH: begin
            st = 1'b1;
         end
         default: begin
            st = 1'b0;
         end
      endcase
      return st;
   endfunction

endpackage

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
(
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_disp_valid,
   input  mem_op_e           i_disp_op,
   input  logic [TAG_W-1:0]  i_disp_rob,
   input  logic [DATA_W-1:0] i_base_val,
   input  logic [TAG_W-1:0]  i_base_tag,
   input  logic              i_base_rdy,
   input  logic [DATA_W-1:0] i_offset,
   input  logic [DATA_W-1:0] i_sdata_val,
   input  logic [TAG_W-1:0]  i_sdata_tag,
   input  logic              i_sdata_rdy,
   output logic              o_disp_ready,
   input  logic              i_cdb_valid,
   input  logic [TAG_W-1:0]  i_cdb_tag,
   input  logic [DATA_W-1:0] i_cdb_data,
   input  logic              i_commit_valid,
   input  logic [TAG_W-1:0]  i_commit_rob,
   output logic              o_mem_valid,
   output mem_op_e           o_mem_op,
   output logic [TAG_W-1:0]  o_mem_rob,
   output logic [DATA_W-1:0] o_mem_addr,
   output logic [DATA_W-1:0] o_mem_data,
   input  logic              i_mem_ready
);

   logic              st_ready;
   logic              sq_ready;
   logic              disp_fire;
   logic              head_valid;
   mem_op_e           head_op;
   logic [TAG_W-1:0]  head_rob;
   logic [DATA_W-1:0] head_addr;
   logic [DATA_W-1:0] head_data;
   logic              head_taken;
   logic              load_conflict;

   lsu_agu_if agu_bus ();

   // both buffers need a free slot to take an instruction.
   assign o_disp_ready = st_ready && sq_ready;
   assign disp_fire    = i_disp_valid && o_disp_ready;

   addr_station u_station (
      .clk          (clk),
      .nrst         (nrst),
      .i_disp_valid (disp_fire),
      .i_disp_op    (i_disp_op),
      .i_disp_rob   (i_disp_rob),
      .i_base_val   (i_base_val),
      .i_base_tag   (i_base_tag),
      .i_base_rdy   (i_base_rdy),
      .i_offset     (i_offset),
      .i_cdb_valid  (i_cdb_valid),
      .i_cdb_tag    (i_cdb_tag),
      .i_cdb_data   (i_cdb_data),
      .o_ready      (st_ready),
      .agu          (agu_bus)
   );

   store_queue u_queue (
      .clk             (clk),
      .nrst            (nrst),
      .i_disp_valid    (disp_fire),
      .i_disp_op       (i_disp_op),
      .i_disp_rob      (i_disp_rob),
      .i_sdata_val     (i_sdata_val),
      .i_sdata_tag     (i_sdata_tag),
      .i_sdata_rdy     (i_sdata_rdy),
      .i_cdb_valid     (i_cdb_valid),
      .i_cdb_tag       (i_cdb_tag),
      .i_cdb_data      (i_cdb_data),
      .i_commit_valid  (i_commit_valid),
      .i_commit_rob    (i_commit_rob),
      .i_head_taken    (head_taken),
      .o_ready         (sq_ready),
      .o_head_valid    (head_valid),
      .o_head_op       (head_op),
      .o_head_rob      (head_rob),
      .o_head_addr     (head_addr),
      .o_head_data     (head_data),
      .o_load_conflict (load_conflict),
      .agu             (agu_bus)
   );

   mem_issue u_issue (
      .clk             (clk),
      .nrst            (nrst),
      .i_head_valid    (head_valid),
      .i_head_op       (head_op),
      .i_head_rob      (head_rob),
      .i_head_addr     (head_addr),
      .i_head_data     (head_data),
      .i_load_conflict (load_conflict),
      .i_mem_ready     (i_mem_ready),
      .o_head_taken    (head_taken),
      .o_mem_valid     (o_mem_valid),
      .o_mem_op        (o_mem_op),
      .o_mem_rob       (o_mem_rob),
      .o_mem_addr      (o_mem_addr),
      .o_mem_data      (o_mem_data),
      .agu             (agu_bus)
   );

endmodule

/* hdl/mem_issue.sv */
`timescale 1ns/1ps

module mem_issue
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
(
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_head_valid,
   input  mem_op_e           i_head_op,
   input  logic [TAG_W-1:0]  i_head_rob,
   input  logic [DATA_W-1:0] i_head_addr,
   input  logic [DATA_W-1:0] i_head_data,
   input  logic              i_load_conflict,
   input  logic              i_mem_ready,
   output logic              o_head_taken,
   output logic              o_mem_valid,
   output mem_op_e           o_mem_op,
   output logic [TAG_W-1:0]  o_mem_rob,
   output logic [DATA_W-1:0] o_mem_addr,
   output logic [DATA_W-1:0] o_mem_data,
   lsu_agu_if.issue          agu
);

   logic slot_free;
   logic load_take;

   // register refills in the cycle it drains.
   assign slot_free = !o_mem_valid || i_mem_ready;

   // committed store beats a waiting load.
   assign o_head_taken = i_head_valid && slot_free;

   // store addresses only go to the queue.
   assign agu.ready = is_store(agu.op) ||
                      (slot_free && !i_head_valid && !i_load_conflict);
   assign load_take = agu.valid && agu.ready && !is_store(agu.op);

   always_ff @(posedge clk) begin
      if (nrst) begin
         o_mem_valid <= 1'b0;
      end else if (slot_free) begin
         o_mem_valid <= o_head_taken || load_take;
      end
   end

   always_ff @(posedge clk) begin
      if (o_head_taken) begin
         o_mem_op   <= i_head_op;
         o_mem_rob  <= i_head_rob;
         o_mem_addr <= i_head_addr;
         o_mem_data <= i_head_data;
      end else if (load_take) begin
         o_mem_op   <= agu.op;
         o_mem_rob  <= agu.rob;
         o_mem_addr <= agu.addr;
         o_mem_data <= '0;
      end
   end

endmodule

/* hdl/store_queue.sv */
`timescale 1ns/1ps

module store_queue
   import lsu_cfg_pkg::*, lsu_isa_pkg::*;
(
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_disp_valid,
   input  mem_op_e           i_disp_op,
   input  logic [TAG_W-1:0]  i_disp_rob,
   input  logic [DATA_W-1:0] i_sdata_val,
   input  logic [TAG_W-1:0]  i_sdata_tag,
   input  logic              i_sdata_rdy,
   input  logic              i_cdb_valid,
   input  logic [TAG_W-1:0]  i_cdb_tag,
   input  logic [DATA_W-1:0] i_cdb_data,
   input  logic              i_commit_valid,
   input  logic [TAG_W-1:0]  i_commit_rob,
   input  logic              i_head_taken,
   output logic              o_ready,
   output logic              o_head_valid,
   output mem_op_e           o_head_op,
   output logic [TAG_W-1:0]  o_head_rob,
   output logic [DATA_W-1:0] o_head_addr,
   output logic [DATA_W-1:0] o_head_data,
   output logic              o_load_conflict,
   lsu_agu_if.queue          agu
);

   logic              ent_valid    [SQ_DEPTH];
   logic              ent_addr_rdy [SQ_DEPTH];
   logic              ent_data_rdy [SQ_DEPTH];
   logic              ent_commit   [SQ_DEPTH];
   mem_op_e           ent_op       [SQ_DEPTH];
   logic [TAG_W-1:0]  ent_rob      [SQ_DEPTH];
   logic [TAG_W-1:0]  ent_tag      [SQ_DEPTH];
   logic [DATA_W-1:0] ent_addr     [SQ_DEPTH];
   logic [DATA_W-1:0] ent_data     [SQ_DEPTH];

   logic [SQ_PTR_W-1:0] head;
   logic [SQ_PTR_W-1:0] tail;
   logic [SQ_CNT_W-1:0] count;
   logic                push;
   logic                new_hit;
   logic                new_commit;
   logic                agu_store;
   logic [SQ_DEPTH-1:0] wr_sel;
   logic [SQ_DEPTH-1:0] cdb_hit;
   logic [SQ_DEPTH-1:0] addr_fill;
   logic [SQ_DEPTH-1:0] commit_hit;
   logic [SQ_DEPTH-1:0] addr_match;

   assign o_ready    = (count != SQ_CNT_W'(SQ_DEPTH));
   assign push       = i_disp_valid && is_store(i_disp_op);
   assign new_hit    = i_cdb_valid && (i_cdb_tag == i_sdata_tag);
   assign new_commit = i_commit_valid && (i_commit_rob == i_disp_rob);
   assign agu_store  = agu.valid && agu.ready && is_store(agu.op);

   always_comb begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         wr_sel[i]     = push && (tail == SQ_PTR_W'(i));
         cdb_hit[i]    = ent_valid[i] && !ent_data_rdy[i] && i_cdb_valid &&
                         (ent_tag[i] == i_cdb_tag);
         addr_fill[i]  = ent_valid[i] && agu_store && (ent_rob[i] == agu.rob);
         commit_hit[i] = ent_valid[i] && i_commit_valid && (ent_rob[i] == i_commit_rob);
         addr_match[i] = ent_valid[i] && ent_addr_rdy[i] && (ent_addr[i] == agu.addr);
      end
   end

   // all older stores already have addresses, the station is in order.
   assign o_load_conflict = agu.valid && !is_store(agu.op) && (|addr_match);

   assign o_head_valid = ent_valid[head] && ent_addr_rdy[head] &&
                         ent_data_rdy[head] && ent_commit[head];
   assign o_head_op    = ent_op[head];
   assign o_head_rob   = ent_rob[head];
   assign o_head_addr  = ent_addr[head];
   assign o_head_data  = ent_data[head];

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         for (int i = 0; i < SQ_DEPTH; i++) begin
            ent_valid[i]    <= 1'b0;
            ent_addr_rdy[i] <= 1'b0;
            ent_data_rdy[i] <= 1'b0;
            ent_commit[i]   <= 1'b0;
         end
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (i_head_taken) begin
            head <= head + 1'b1;
         end
         if (push && !i_head_taken) begin
            count <= count + 1'b1;
         end else if (!push && i_head_taken) begin
            count <= count - 1'b1;
         end
         for (int i = 0; i < SQ_DEPTH; i++) begin
            if (wr_sel[i]) begin
               ent_valid[i]    <= 1'b1;
               ent_addr_rdy[i] <= 1'b0;
               ent_data_rdy[i] <= i_sdata_rdy || new_hit;
               ent_commit[i]   <= new_commit;
            end else begin
               if (cdb_hit[i]) begin
                  ent_data_rdy[i] <= 1'b1;
               end
               if (addr_fill[i]) begin
                  ent_addr_rdy[i] <= 1'b1;
               end
               if (commit_hit[i]) begin
                  ent_commit[i] <= 1'b1;
               end
            end
            if (i_head_taken && (head == SQ_PTR_W'(i))) begin
               ent_valid[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         if (wr_sel[i]) begin
            ent_op[i]   <= i_disp_op;
            ent_rob[i]  <= i_disp_rob;
            ent_tag[i]  <= i_sdata_tag;
            ent_data[i] <= i_sdata_rdy ? i_sdata_val : i_cdb_data;
         end else if (cdb_hit[i]) begin
            ent_data[i] <= i_cdb_data;
         end
         if (addr_fill[i]) begin
            ent_addr[i] <= agu.addr;
         end
      end
   end

endmodule

/* lsu_top.f */
hdl/lsu_cfg_pkg.sv
hdl/lsu_isa_pkg.sv
hdl/lsu_agu_if.sv
hdl/addr_station.sv
hdl/store_queue.sv
hdl/mem_issue.sv
hdl/lsu_top.sv
bench/lsu_sva.sv
bench/lsu_tb.sv
